// File: design/hist_pkg.sv
`default_nettype none

package hist_pkg;

    // time bin code and bin count per pixel
    localparam int BIN_W = 4;
    localparam int BIN_NUM = 1 << BIN_W;

    // frame geometry
    localparam int PIXEL_NUM = 4;
    localparam int EVENTS_PER_PIXEL = 2;
    localparam int ACQ_NUM = 3;

    // counter widths inside the builder
    localparam int PIX_W = 2;
    localparam int EV_W = 1;
    localparam int ACQ_W = 2;

    // histogram word and memory shape
    localparam int COUNT_W = 8;
    // bank bit, pixel, bin
    localparam int ADDR_W = 1 + PIX_W + BIN_W;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    // one photon event, bin code only
    typedef struct packed {
        logic [BIN_W-1:0] bin;
    } event_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // memory client request, 16 bits
    typedef struct packed {
        mem_op_e            op;
        logic [ADDR_W-1:0]  addr;
        logic [COUNT_W-1:0] wdata;
    } mem_req_t;

    // peak record, 15 bits
    typedef struct packed {
        logic               bank;
        logic [PIX_W-1:0]   pixel;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } peak_t;

    typedef enum logic [2:0] {
        B_IDLE,
        B_READ,
        B_WRITE,
        B_ACK,
        B_WAIT_BANK
    } build_state_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_CLEAR,
        S_REPORT,
        S_WAIT_DROP
    } scan_state_e;

endpackage

`default_nettype wire

// File: design/hist_ram.sv
`timescale 1ns/1ns
`default_nettype none

module hist_ram import hist_pkg::*; (
    input  logic               clk,
    input  logic [ADDR_W-1:0]  addr,
    input  logic               we,
    input  logic [COUNT_W-1:0] wdata,
    output logic [COUNT_W-1:0] rdata
);

    // two banks of PIXEL_NUM x BIN_NUM counts
    logic [COUNT_W-1:0] mem [MEM_DEPTH];

    // write lands in the addressed cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old word on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: design/hist_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module hist_arbiter import hist_pkg::*; (
    input  logic               clk,
    input  logic               res,
    // builder side
    input  logic               bld_req,
    input  mem_req_t           bld_mreq,
    output logic               bld_ack,
    // readout side
    input  logic               rd_req,
    input  mem_req_t           rd_mreq,
    output logic               rd_ack,
    // read data back to whichever client holds ack
    output logic [COUNT_W-1:0] rdata,
    // memory port
    output logic [ADDR_W-1:0]  ram_addr,
    output logic               ram_we,
    output logic [COUNT_W-1:0] ram_wdata,
    input  logic [COUNT_W-1:0] ram_rdata
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_MEM,
        A_WAIT,
        A_ACK
    } arb_state_e;

    arb_state_e state;
    // client in service and the one served last (1 is readout)
    logic       sel_rd;
    logic       grant_rd;
    mem_req_t   cur;

    // readout wins alone, or on a tie when the builder went last
    assign grant_rd = rd_req && (!bld_req || !sel_rd);

    // port follows the selected client
    assign cur       = sel_rd ? rd_mreq : bld_mreq;
    assign ram_addr  = cur.addr;
    assign ram_wdata = cur.wdata;
    // strobe only in the single access cycle
    assign ram_we    = (state == A_MEM) && (cur.op == MEM_WRITE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= A_IDLE;
            sel_rd  <= 1'b0;
            bld_ack <= 1'b0;
            rd_ack  <= 1'b0;
        end else begin
            case (state)
                A_IDLE: begin
                    if (bld_req || rd_req) begin
                        sel_rd <= grant_rd;
                        state  <= A_MEM;
                    end
                end
                // address went out, read word appears next edge
                A_MEM: state <= A_WAIT;
                A_WAIT: begin
                    if (sel_rd) begin
                        rd_ack <= 1'b1;
                    end else begin
                        bld_ack <= 1'b1;
                    end
                    state <= A_ACK;
                end
                // hold ack until the served client lets go
                A_ACK: begin
                    if (sel_rd ? !rd_req : !bld_req) begin
                        rd_ack  <= 1'b0;
                        bld_ack <= 1'b0;
                        state   <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

    // capture read word, held while ack is up
    always_ff @(posedge clk) begin
        if (state == A_WAIT) begin
            rdata <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/hist_builder.sv
`timescale 1ns/1ns
`default_nettype none

module hist_builder import hist_pkg::*; (
    input  logic               clk,
    input  logic               res,
    // event link
    input  logic               ev_req,
    input  event_t             ev,
    output logic               ev_ack,
    // memory client
    output logic               mem_req,
    output mem_req_t           mreq,
    input  logic               mem_ack,
    input  logic [COUNT_W-1:0] mem_rdata,
    // bank hand-off
    output logic               frame_done,
    output logic               fill_bank,
    input  logic               scan_busy
);

    build_state_e       state;
    // position inside the frame
    logic [EV_W-1:0]    ev_cnt;
    logic [PIX_W-1:0]   pix_cnt;
    logic [ACQ_W-1:0]   acq_cnt;
    // count read back for the current event
    logic [COUNT_W-1:0] count_q;
    // start-up sweep of both banks
    logic               init;
    logic [ADDR_W-1:0]  clr_addr;
    logic               last_ev;
    logic               last_pix;
    logic               last_acq;
    logic               frame_end;

    assign last_ev   = (ev_cnt == EV_W'(EVENTS_PER_PIXEL - 1));
    assign last_pix  = (pix_cnt == PIX_W'(PIXEL_NUM - 1));
    assign last_acq  = (acq_cnt == ACQ_W'(ACQ_NUM - 1));
    assign frame_end = last_ev && last_pix && last_acq;

    // bin address from bank, pixel and event code
    always_comb begin
        mreq.op    = (state == B_WRITE) ? MEM_WRITE : MEM_READ;
        mreq.addr  = init ? clr_addr : {fill_bank, pix_cnt, ev.bin};
        mreq.wdata = init ? '0 : count_q + COUNT_W'(1);
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= B_IDLE;
            ev_ack     <= 1'b0;
            mem_req    <= 1'b0;
            frame_done <= 1'b0;
            fill_bank  <= 1'b0;
            ev_cnt     <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            count_q    <= '0;
            init       <= 1'b1;
            clr_addr   <= '0;
        end else begin
            // single-cycle strobe
            frame_done <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (init) begin
                        state <= B_WRITE;
                    end else if (ev_req) begin
                        state <= B_READ;
                    end
                end
                // fetch current count
                B_READ: begin
                    if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                    end else if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        count_q <= mem_rdata;
                        state   <= B_WRITE;
                    end
                end
                // count + 1, or zero during the sweep
                B_WRITE: begin
                    if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                    end else if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        if (!init) begin
                            state <= B_ACK;
                        end else begin
                            clr_addr <= clr_addr + ADDR_W'(1);
                            if (&clr_addr) begin
                                init  <= 1'b0;
                                state <= B_IDLE;
                            end
                        end
                    end
                end
                B_ACK: begin
                    if (!ev_ack) begin
                        // event first, then pixel, then acquisition
                        if (last_ev) begin
                            ev_cnt <= '0;
                            if (last_pix) begin
                                pix_cnt <= '0;
                                acq_cnt <= last_acq ? '0 : acq_cnt + ACQ_W'(1);
                            end else begin
                                pix_cnt <= pix_cnt + PIX_W'(1);
                            end
                        end else begin
                            ev_cnt <= ev_cnt + EV_W'(1);
                        end
                        if (!frame_end) begin
                            ev_ack <= 1'b1;
                        end else if (scan_busy) begin
                            // other bank still under scan
                            state <= B_WAIT_BANK;
                        end else begin
                            frame_done <= 1'b1;
                            fill_bank  <= ~fill_bank;
                            ev_ack     <= 1'b1;
                        end
                    end else if (!ev_req) begin
                        ev_ack <= 1'b0;
                        state  <= B_IDLE;
                    end
                end
                B_WAIT_BANK: begin
                    if (!scan_busy) begin
                        frame_done <= 1'b1;
                        fill_bank  <= ~fill_bank;
                        ev_ack     <= 1'b1;
                        state      <= B_ACK;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/hist_readout.sv
`timescale 1ns/1ns
`default_nettype none

module hist_readout import hist_pkg::*; (
    input  logic               clk,
    input  logic               res,
    // bank hand-off
    input  logic               fill_bank,
    input  logic               frame_done,
    output logic               scan_busy,
    // memory client
    output logic               mem_req,
    output mem_req_t           mreq,
    input  logic               mem_ack,
    input  logic [COUNT_W-1:0] mem_rdata,
    // peak link
    output logic               peak_req,
    output peak_t              peak,
    input  logic               peak_ack
);

    scan_state_e        state;
    // scan cursor
    logic               bank;
    logic [PIX_W-1:0]   pix;
    logic [BIN_W-1:0]   bin;
    // running maximum of the pixel
    logic [BIN_W-1:0]   best_bin;
    logic [COUNT_W-1:0] best_cnt;
    logic               last_bin;
    logic               clear_done;

    assign last_bin   = (bin == BIN_W'(BIN_NUM - 1));
    // zero write of the pixel's final bin acknowledged
    assign clear_done = (state == S_CLEAR) && mem_req && mem_ack && last_bin;

    // read the bin, then write zero back to it
    always_comb begin
        mreq.op    = (state == S_CLEAR) ? MEM_WRITE : MEM_READ;
        mreq.addr  = {bank, pix, bin};
        mreq.wdata = '0;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= S_IDLE;
            scan_busy <= 1'b0;
            mem_req   <= 1'b0;
            peak_req  <= 1'b0;
            bank      <= 1'b0;
            pix       <= '0;
            bin       <= '0;
            best_bin  <= '0;
            best_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (frame_done) begin
                        // fill_bank already flipped, scan the other one
                        bank      <= ~fill_bank;
                        pix       <= '0;
                        bin       <= '0;
                        best_bin  <= '0;
                        best_cnt  <= '0;
                        scan_busy <= 1'b1;
                        state     <= S_READ;
                    end
                end
                S_READ: begin
                    if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                    end else if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        // strictly greater keeps the lower bin on ties
                        if (mem_rdata > best_cnt) begin
                            best_cnt <= mem_rdata;
                            best_bin <= bin;
                        end
                        state <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                    end else if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        if (last_bin) begin
                            peak_req <= 1'b1;
                            state    <= S_REPORT;
                        end else begin
                            bin   <= bin + BIN_W'(1);
                            state <= S_READ;
                        end
                    end
                end
                S_REPORT: begin
                    if (peak_ack) begin
                        peak_req <= 1'b0;
                        state    <= S_WAIT_DROP;
                    end
                end
                // four-phase return, then next pixel or done
                S_WAIT_DROP: begin
                    if (!peak_ack) begin
                        if (pix == PIX_W'(PIXEL_NUM - 1)) begin
                            scan_busy <= 1'b0;
                            state     <= S_IDLE;
                        end else begin
                            pix      <= pix + PIX_W'(1);
                            bin      <= '0;
                            best_bin <= '0;
                            best_cnt <= '0;
                            state    <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // record loaded once per pixel, stable through the handshake
    always_ff @(posedge clk) begin
        if (clear_done) begin
            peak <= '{bank: bank, pixel: pix, bin: best_bin, count: best_cnt};
        end
    end

endmodule

`default_nettype wire

// File: design/hist_top.sv
`timescale 1ns/1ns
`default_nettype none

module hist_top import hist_pkg::*; (
    input  logic   clk,
    input  logic   res,
    // event link
    input  logic   ev_req,
    input  event_t ev,
    output logic   ev_ack,
    // peak link
    output logic   peak_req,
    output peak_t  peak,
    input  logic   peak_ack
);

    // memory clients
    logic               bld_req;
    logic               bld_ack;
    mem_req_t           bld_mreq;
    logic               rd_req;
    logic               rd_ack;
    mem_req_t           rd_mreq;
    logic [COUNT_W-1:0] rdata;
    // memory port
    logic [ADDR_W-1:0]  ram_addr;
    logic               ram_we;
    logic [COUNT_W-1:0] ram_wdata;
    logic [COUNT_W-1:0] ram_rdata;
    // bank hand-off
    logic               frame_done;
    logic               fill_bank;
    logic               scan_busy;

    hist_builder u_builder (
        .clk        (clk),
        .res        (res),
        .ev_req     (ev_req),
        .ev         (ev),
        .ev_ack     (ev_ack),
        .mem_req    (bld_req),
        .mreq       (bld_mreq),
        .mem_ack    (bld_ack),
        .mem_rdata  (rdata),
        .frame_done (frame_done),
        .fill_bank  (fill_bank),
        .scan_busy  (scan_busy)
    );

    hist_readout u_readout (
        .clk        (clk),
        .res        (res),
        .fill_bank  (fill_bank),
        .frame_done (frame_done),
        .scan_busy  (scan_busy),
        .mem_req    (rd_req),
        .mreq       (rd_mreq),
        .mem_ack    (rd_ack),
        .mem_rdata  (rdata),
        .peak_req   (peak_req),
        .peak       (peak),
        .peak_ack   (peak_ack)
    );

    hist_arbiter u_arbiter (
        .clk        (clk),
        .res        (res),
        .bld_req    (bld_req),
        .bld_mreq   (bld_mreq),
        .bld_ack    (bld_ack),
        .rd_req     (rd_req),
        .rd_mreq    (rd_mreq),
        .rd_ack     (rd_ack),
        .rdata      (rdata),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    hist_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: bench/hist_props.sv
`timescale 1ns/1ns
`default_nettype none

module hist_props import hist_pkg::*; (
    input logic  clk,
    input logic  res,
    input logic  ev_req,
    input logic  ev_ack,
    input logic  peak_req,
    input peak_t peak,
    input logic  bld_ack,
    input logic  rd_ack
);

    // failed assertion count
    int assert_fails = 0;

    // ack only answers a pending request, req seen on the edge that raised ack
    ev_ack_needs_req: assert property (@(posedge clk) disable iff (!res)
        $rose(ev_ack) |-> $past(ev_req))
        else begin
            $error("ev_ack rose while ev_req was low");
            assert_fails++;
        end

    // record held for the whole handshake
    peak_held: assert property (@(posedge clk) disable iff (!res)
        ($past(peak_req) && peak_req) |-> $stable(peak))
        else begin
            $error("peak changed while peak_req was high");
            assert_fails++;
        end

    // one memory access in flight
    acks_exclusive: assert property (@(posedge clk) disable iff (!res)
        !(bld_ack && rd_ack))
        else begin
            $error("bld_ack and rd_ack high together");
            assert_fails++;
        end

    // quiet memory side right after reset release
    acks_low_after_reset: assert property (@(posedge clk)
        $rose(res) |-> (!bld_ack && !rd_ack))
        else begin
            $error("memory ack high in the first cycle after reset");
            assert_fails++;
        end

endmodule

bind hist_top hist_props u_props (
    .clk      (clk),
    .res      (res),
    .ev_req   (ev_req),
    .ev_ack   (ev_ack),
    .peak_req (peak_req),
    .peak     (peak),
    .bld_ack  (bld_ack),
    .rd_ack   (rd_ack)
);

`default_nettype wire

// File: bench/hist_tb.sv
`timescale 1ns/1ns
`default_nettype none

module hist_tb import hist_pkg::*; ();

    localparam int FRAME_NUM = 3;
    localparam int EV_PER_FRAME = ACQ_NUM * PIXEL_NUM * EVENTS_PER_PIXEL;
    localparam int EV_TOTAL = FRAME_NUM * EV_PER_FRAME;
    localparam int PEAK_TOTAL = FRAME_NUM * PIXEL_NUM;
    // cycle limits, first event also covers the start-up bank sweep
    localparam int ACK_LIMIT = 4000;
    localparam int PEAK_LIMIT = 8000;

    logic   clk;
    logic   res;
    logic   ev_req;
    event_t ev;
    logic   ev_ack;
    logic   peak_req;
    peak_t  peak;
    logic   peak_ack;

    // bin codes, one per event, frame then acquisition then pixel
    logic [BIN_W-1:0] ev_table [EV_TOTAL];
    peak_t            exp_peaks [PEAK_TOTAL];
    int               value_errs = 0;
    int               timeout_errs = 0;
    int               acked = 0;
    int               rec_cnt = 0;
    integer           seed = 32'hd22349b9;

    hist_top dut (
        .clk      (clk),
        .res      (res),
        .ev_req   (ev_req),
        .ev       (ev),
        .ev_ack   (ev_ack),
        .peak_req (peak_req),
        .peak     (peak),
        .peak_ack (peak_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_peak(input string name, input peak_t exp, input peak_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // histogram per frame and pixel, highest count, lowest bin on ties
    task automatic compute_peaks();
        int hist [PIXEL_NUM][BIN_NUM];
        int f;
        int a;
        int p;
        int e;
        int b;
        int best;
        int best_bin;
        for (f = 0; f < FRAME_NUM; f++) begin
            for (p = 0; p < PIXEL_NUM; p++) begin
                for (b = 0; b < BIN_NUM; b++) begin
                    hist[p][b] = 0;
                end
            end
            for (a = 0; a < ACQ_NUM; a++) begin
                for (p = 0; p < PIXEL_NUM; p++) begin
                    for (e = 0; e < EVENTS_PER_PIXEL; e++) begin
                        b = ev_table[f * EV_PER_FRAME + (a * PIXEL_NUM + p)
                            * EVENTS_PER_PIXEL + e];
                        hist[p][b]++;
                    end
                end
            end
            for (p = 0; p < PIXEL_NUM; p++) begin
                best = 0;
                best_bin = 0;
                for (b = 0; b < BIN_NUM; b++) begin
                    if (hist[p][b] > best) begin
                        best = hist[p][b];
                        best_bin = b;
                    end
                end
                // banks alternate from 0
                exp_peaks[f * PIXEL_NUM + p] = '{bank: f[0], pixel: p[PIX_W-1:0],
                    bin: best_bin[BIN_W-1:0], count: best[COUNT_W-1:0]};
            end
        end
    endtask

    // four-phase event send
    task automatic send_event(input event_t e);
        int t;
        ev = e;
        ev_req = 1'b1;
        t = 0;
        while (ev_ack !== 1'b1 && t < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (ev_ack !== 1'b1) begin
            timeout_errs++;
            $display("event with bin %0d was never acknowledged", e.bin);
        end else begin
            acked++;
        end
        ev_req = 1'b0;
        t = 0;
        while (ev_ack !== 1'b0 && t < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (ev_ack !== 1'b0) begin
            timeout_errs++;
            $display("ev_ack stayed high after ev_req dropped");
        end
    endtask

    // peak collector, random ack delay stalls the scan
    initial begin : collect
        int t;
        int d;
        int k;
        logic give_up;
        peak_ack = 1'b0;
        give_up = 1'b0;
        for (k = 0; k < PEAK_TOTAL && !give_up; k++) begin
            t = 0;
            while (peak_req !== 1'b1 && t < PEAK_LIMIT) begin
                @(posedge clk);
                #1;
                t++;
            end
            if (peak_req !== 1'b1) begin
                timeout_errs++;
                $display("peak record %0d never arrived", k);
                give_up = 1'b1;
            end else begin
                check_peak("peak", exp_peaks[k], peak);
                rec_cnt++;
                d = $random(seed) & 32'h3f;
                repeat (d + 1) @(posedge clk);
                #1;
                peak_ack = 1'b1;
                t = 0;
                while (peak_req !== 1'b0 && t < PEAK_LIMIT) begin
                    @(posedge clk);
                    #1;
                    t++;
                end
                if (peak_req !== 1'b0) begin
                    timeout_errs++;
                    $display("peak_req stayed high after peak_ack rose");
                    give_up = 1'b1;
                end
                peak_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int t;
        int i;
        res = 1'b0;
        ev_req = 1'b0;
        ev = '0;
        // ties in frame 0 pixels 0 and 2, frame 1 pixel 1, frame 2 pixels 1 and 3
        ev_table = '{
            4'd5, 4'd5, 4'd9, 4'd9, 4'd12, 4'd1, 4'd0, 4'd15,
            4'd5, 4'd3, 4'd9, 4'd9, 4'd12, 4'd1, 4'd15, 4'd15,
            4'd3, 4'd3, 4'd9, 4'd2, 4'd4, 4'd7, 4'd15, 4'd0,
            4'd7, 4'd7, 4'd10, 4'd11, 4'd0, 4'd0, 4'd6, 4'd8,
            4'd7, 4'd7, 4'd10, 4'd11, 4'd1, 4'd2, 4'd8, 4'd6,
            4'd7, 4'd7, 4'd11, 4'd10, 4'd3, 4'd4, 4'd6, 4'd14,
            4'd2, 4'd2, 4'd4, 4'd4, 4'd14, 4'd14, 4'd1, 4'd2,
            4'd8, 4'd8, 4'd4, 4'd13, 4'd11, 4'd6, 4'd3, 4'd4,
            4'd8, 4'd1, 4'd13, 4'd13, 4'd14, 4'd9, 4'd5, 4'd6
        };
        compute_peaks();
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        // idle outputs before any event
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            check_bit("ev_ack", 1'b0, ev_ack);
            check_bit("peak_req", 1'b0, peak_req);
        end
        for (i = 0; i < EV_TOTAL; i++) begin
            send_event('{bin: ev_table[i]});
        end
        t = 0;
        while (rec_cnt < PEAK_TOTAL && t < PEAK_LIMIT * 2) begin
            @(posedge clk);
            t++;
        end
        // nothing extra after the last frame
        repeat (200) @(posedge clk);
        #1;
        check_bit("peak_req", 1'b0, peak_req);
        if (acked != EV_TOTAL || rec_cnt != PEAK_TOTAL) begin
            timeout_errs++;
            $display("only %0d events acknowledged and %0d peak records received",
                acked, rec_cnt);
        end
        $display("errors: %0d value, %0d timeout, %0d assertion", value_errs, timeout_errs,
            dut.u_props.assert_fails);
        if (value_errs == 0 && timeout_errs == 0 && dut.u_props.assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/hist_pkg.sv
design/hist_ram.sv
design/hist_arbiter.sv
design/hist_builder.sv
design/hist_readout.sv
design/hist_top.sv
bench/hist_props.sv
bench/hist_tb.sv
